//--- rename_stage.f
common/rename_pkg.sv
rename/rename_free_list.sv
rename/rename_map_table.sv
rename/rename_dep_check.sv
rename/rename_stage.sv
tests/rename_tb.sv

//--- tests/rename_tb.sv
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

    logic                                   clk = 1'b0;
    logic                                   i_arst_n;
    logic  [RENAME_WIDTH-1:0]               i_dec_vld;
    logic  [RENAME_WIDTH-1:0]               i_dec_rd_wen;
    lreg_t [RENAME_WIDTH-1:0]               i_dec_lrd;
    lreg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] i_dec_lrs;
    pc_t   [RENAME_WIDTH-1:0]               i_dec_pc;
    uop_t  [RENAME_WIDTH-1:0]               i_dec_uop;
    logic                                   o_stall;
    logic                                   i_stall;
    logic  [RENAME_WIDTH-1:0]               i_commit_vld;
    lreg_t [RENAME_WIDTH-1:0]               i_commit_lrd;
    preg_t [RENAME_WIDTH-1:0]               i_commit_prd;
    preg_t [RENAME_WIDTH-1:0]               i_commit_prev_prd;
    logic                                   i_squash;
    logic  [RENAME_WIDTH-1:0]               o_ren_vld;
    preg_t [RENAME_WIDTH-1:0]               o_ren_prd;
    preg_t [RENAME_WIDTH-1:0]               o_ren_prev_prd;
    preg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] o_ren_prs;
    lreg_t [RENAME_WIDTH-1:0]               o_ren_lrd;
    logic  [RENAME_WIDTH-1:0]               o_ren_rd_wen;
    pc_t   [RENAME_WIDTH-1:0]               o_ren_pc;
    uop_t  [RENAME_WIDTH-1:0]               o_ren_uop;

    // ******************************************************************
    // shadow model
    // ******************************************************************
    preg_t                                  spec_map   [NUM_LREGS];
    preg_t                                  commit_map [NUM_LREGS];
    logic  [NUM_PREGS-1:0]                  spec_free;
    logic  [NUM_PREGS-1:0]                  commit_free;
    logic  [16:0]                           pend_q [$];   // {lrd, prd, prev_prd} oldest first
    logic  [RENAME_WIDTH-1:0]               exp_vld;
    logic  [RENAME_WIDTH-1:0]               exp_req;
    preg_t [RENAME_WIDTH-1:0]               exp_prd;
    preg_t [RENAME_WIDTH-1:0]               exp_prev;
    preg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] exp_prs;
    logic  [RENAME_WIDTH-1:0]               exp_wen;
    lreg_t [RENAME_WIDTH-1:0]               exp_lrd;
    pc_t   [RENAME_WIDTH-1:0]               exp_pc;
    uop_t  [RENAME_WIDTH-1:0]               exp_uop;
    logic                                   squash_q;
    integer                                 seed = 13506;
    pc_t                                    pc_next = 32'h0000_1000;

    rename_stage dut (.*);

    always #5 clk = ~clk;

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic set_lane(input int l, input bit v, input bit w, input int rd,
                            input int s0, input int s1);
        i_dec_vld[l]    = v;
        i_dec_rd_wen[l] = w;
        i_dec_lrd[l]    = lreg_t'(rd);
        i_dec_lrs[l][0] = lreg_t'(s0);
        i_dec_lrs[l][1] = lreg_t'(s1);
        i_dec_pc[l]     = pc_next;
        i_dec_uop[l]    = uop_t'(($random(seed) & 255) % 13);
        pc_next         = pc_next + 4;
    endtask

    // narrow register range so lanes collide often
    task automatic random_group(input bit busy);
        for (int l = 0; l < RENAME_WIDTH; l++)
            set_lane(l, busy || ($random(seed) & 3) != 0, busy || ($random(seed) & 3) != 0,
                     busy ? 1 + (($random(seed) & 63) % 7) : $random(seed) & 7,
                     $random(seed) & 7, $random(seed) & 7);
    endtask

    task automatic set_ctrl(input int ncommit, input bit sq, input bit stl);
        i_commit_vld      = '0;
        i_commit_lrd      = '0;
        i_commit_prd      = '0;
        i_commit_prev_prd = '0;
        for (int l = 0; l < ncommit && pend_q.size() > 0; l++) begin
            {i_commit_lrd[l], i_commit_prd[l], i_commit_prev_prd[l]} = pend_q.pop_front();
            i_commit_vld[l] = 1'b1;
        end
        i_squash = sq;
        i_stall  = stl;
    endtask

    // one cycle, called on a falling edge with the inputs already driven
    task automatic step();
        logic [NUM_PREGS-1:0]    free_before;
        logic [RENAME_WIDTH-1:0] req;
        logic                    can;
        logic                    accept;
        preg_t                   lo [2];
        preg_t                   new_prd [2];
        preg_t                   prev [2];
        preg_t                   src [2][2];
        #1;
        can    = ($countones(spec_free) >= 2);
        accept = can && !i_stall && !i_squash;
        assert (o_stall == (!can || i_stall))
            else stop_on_error($sformatf("[ERROR] %0t: o_stall is %b", $time, o_stall));
        free_before = spec_free;
        lo[0] = '0;
        lo[1] = '0;
        for (int i = NUM_PREGS - 1; i > 0; i--) begin
            if (spec_free[i]) begin
                lo[1] = lo[0];
                lo[0] = preg_t'(i);
            end
        end
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            req[l]  = i_dec_vld[l] && i_dec_rd_wen[l] && (i_dec_lrd[l] != '0);
            prev[l] = spec_map[i_dec_lrd[l]];
            for (int s = 0; s < NUM_SRCS; s++)
                src[l][s] = spec_map[i_dec_lrs[l][s]];
        end
        new_prd[0] = lo[0];
        new_prd[1] = req[0] ? lo[1] : lo[0];
        if (req[0] && i_dec_lrd[1] == i_dec_lrd[0])
            prev[1] = new_prd[0];
        for (int s = 0; s < NUM_SRCS; s++)
            if (req[0] && i_dec_lrs[1][s] == i_dec_lrd[0])
                src[1][s] = new_prd[0];
        @(posedge clk);
        if (!i_stall) begin
            for (int l = 0; l < RENAME_WIDTH; l++) begin
                exp_prd[l]  = req[l] ? new_prd[l] : '0;
                exp_prev[l] = prev[l];
                for (int s = 0; s < NUM_SRCS; s++)
                    exp_prs[l][s] = src[l][s];
            end
            exp_req = req;
            exp_wen = i_dec_rd_wen;
            exp_lrd = i_dec_lrd;
            exp_pc  = i_dec_pc;
            exp_uop = i_dec_uop;
            exp_vld = can ? i_dec_vld : '0;
        end
        if (i_squash)
            exp_vld = '0;
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            if (accept && req[l]) begin
                spec_free[new_prd[l]]  = 1'b0;
                spec_map[i_dec_lrd[l]] = new_prd[l];
                pend_q.push_back({i_dec_lrd[l], new_prd[l], prev[l]});
            end
        end
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            if (i_commit_vld[l]) begin
                commit_map[i_commit_lrd[l]]       = i_commit_prd[l];
                commit_free[i_commit_prd[l]]      = 1'b0;
                commit_free[i_commit_prev_prd[l]] = 1'b1;
                spec_free[i_commit_prev_prd[l]]   = 1'b1;   // reusable next cycle
            end
        end
        if (i_squash) begin
            spec_map  = commit_map;
            spec_free = commit_free;
            pend_q.delete();
        end
        @(negedge clk);
        assert (o_ren_vld == exp_vld)
            else stop_on_error($sformatf("[ERROR] %0t: o_ren_vld %b, expected %b",
                                         $time, o_ren_vld, exp_vld));
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            if (accept && exp_req[l]) begin
                assert (free_before[o_ren_prd[l]])
                    else stop_on_error($sformatf("[ERROR] %0t: p%0d was not free",
                                                 $time, o_ren_prd[l]));
            end
        end
        if (accept && (&exp_req)) begin
            assert (o_ren_prd[0] != o_ren_prd[1])
                else stop_on_error($sformatf("[ERROR] %0t: both lanes got p%0d",
                                             $time, o_ren_prd[0]));
        end
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            if (exp_vld[l]) begin
                assert (o_ren_prd[l] == exp_prd[l] && o_ren_prs[l] == exp_prs[l]
                        && (!exp_req[l] || o_ren_prev_prd[l] == exp_prev[l]))
                    else stop_on_error($sformatf(
                        "[ERROR] %0t: lane %0d prd/prev/prs %0d/%0d/%h, expected %0d/%0d/%h",
                        $time, l, o_ren_prd[l], o_ren_prev_prd[l], o_ren_prs[l],
                        exp_prd[l], exp_prev[l], exp_prs[l]));
                assert ({o_ren_lrd[l], o_ren_rd_wen[l], o_ren_pc[l], o_ren_uop[l]} ==
                        {exp_lrd[l], exp_wen[l], exp_pc[l], exp_uop[l]})
                    else stop_on_error($sformatf("[ERROR] %0t: lane %0d lrd/pc/uop differ",
                                                 $time, l));
            end
        end
    endtask

    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n)
            squash_q <= 1'b0;
        else
            squash_q <= i_squash;
    end

    // squash leaves a bubble and p0 is never handed out
    always @(negedge clk) begin
        if (i_arst_n && squash_q) begin
            assert (o_ren_vld == '0)
                else stop_on_error($sformatf("[ERROR] %0t: o_ren_vld %b after squash",
                                             $time, o_ren_vld));
        end
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            if (o_ren_vld[l] && o_ren_rd_wen[l] && o_ren_lrd[l] != '0) begin
                assert (o_ren_prd[l] != '0)
                    else stop_on_error($sformatf("[ERROR] %0t: lane %0d renamed to p0", $time, l));
            end
        end
    end

    // ******************************************************************
    // stimulus
    // ******************************************************************
    initial begin
        preg_t [RENAME_WIDTH-1:0] prd_snap;
        pc_t   [RENAME_WIDTH-1:0] pc_snap;
        int                       n;
        i_arst_n     = 1'b0;
        i_dec_vld    = '0;
        i_dec_rd_wen = '0;
        i_dec_lrd    = '0;
        i_dec_lrs    = '0;
        i_dec_pc     = '0;
        i_dec_uop    = {UOP_NOP, UOP_NOP};
        set_ctrl(0, 1'b0, 1'b0);
        for (int i = 0; i < NUM_LREGS; i++) begin
            spec_map[i]   = preg_t'(i);
            commit_map[i] = preg_t'(i);
        end
        for (int i = 0; i < NUM_PREGS; i++)
            spec_free[i] = (i >= NUM_LREGS);
        commit_free = spec_free;
        exp_vld     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        assert (o_ren_vld == '0 && !o_stall)
            else stop_on_error($sformatf("[ERROR] %0t: wrong state after reset", $time));

        set_lane(0, 1'b1, 1'b1, 5, 1, 2);
        set_lane(1, 1'b1, 1'b1, 7, 3, 4);
        step();
        assert (o_ren_prd == {preg_t'(33), preg_t'(32)} && o_ren_prs[1][1] == preg_t'(4))
            else stop_on_error($sformatf("[ERROR] %0t: first allocation not p32/p33", $time));

        set_lane(0, 1'b1, 1'b1, 9, 5, 7);   // lane 1 reads and rewrites x9
        set_lane(1, 1'b1, 1'b1, 9, 9, 0);
        step();
        assert (o_ren_prs[1][0] == o_ren_prd[0] && o_ren_prev_prd[1] == o_ren_prd[0])
            else stop_on_error($sformatf("[ERROR] %0t: lane 1 missed the lane 0 bypass", $time));
        set_lane(0, 1'b1, 1'b1, 0, 9, 9);   // x0 destination
        set_lane(1, 1'b1, 1'b1, 3, 0, 9);
        step();

        prd_snap = o_ren_prd;
        pc_snap  = o_ren_pc;
        for (int k = 0; k < 3; k++) begin
            random_group(1'b1);
            set_ctrl(0, 1'b0, 1'b1);
            step();
            assert (o_ren_prd == prd_snap && o_ren_pc == pc_snap)
                else stop_on_error($sformatf("[ERROR] %0t: outputs moved under i_stall", $time));
        end

        // drain the free list, then recover through commits
        n = 0;
        do begin
            if (n == 30)
                stop_on_error("timeout: o_stall did not rise within 30 cycles");
            random_group(1'b1);
            set_ctrl(0, 1'b0, 1'b0);
            step();
            n++;
        end while (!o_stall);
        random_group(1'b1);
        step();
        assert (o_ren_vld == '0)
            else stop_on_error($sformatf("[ERROR] %0t: no bubble while out of regs", $time));
        n = 0;
        do begin
            if (n == 50)
                stop_on_error("timeout: o_stall stayed high for 50 cycles");
            random_group(1'b1);
            set_ctrl(2, 1'b0, 1'b0);
            step();
            n++;
        end while (o_stall);

        for (int k = 0; k < 300; k++) begin
            random_group(1'b0);
            set_ctrl(($random(seed) & 15) % 3, ($random(seed) & 31) == 0,
                     ($random(seed) & 7) == 0);
            step();
        end
        random_group(1'b0);
        set_ctrl(1, 1'b1, 1'b0);   // squash with a commit in the same cycle
        step();
        random_group(1'b1);
        set_ctrl(0, 1'b0, 1'b0);
        step();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- rename/rename_stage.sv
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
    input  logic                                   clk,
    input  logic                                   i_arst_n,
    // from decode
    input  logic  [RENAME_WIDTH-1:0]               i_dec_vld,
    input  logic  [RENAME_WIDTH-1:0]               i_dec_rd_wen,
    input  lreg_t [RENAME_WIDTH-1:0]               i_dec_lrd,
    input  lreg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] i_dec_lrs,
    input  pc_t   [RENAME_WIDTH-1:0]               i_dec_pc,
    input  uop_t  [RENAME_WIDTH-1:0]               i_dec_uop,
    output logic                                   o_stall,
    // from dispatch
    input  logic                                   i_stall,
    // from commit
    input  logic  [RENAME_WIDTH-1:0]               i_commit_vld,
    input  lreg_t [RENAME_WIDTH-1:0]               i_commit_lrd,
    input  preg_t [RENAME_WIDTH-1:0]               i_commit_prd,
    input  preg_t [RENAME_WIDTH-1:0]               i_commit_prev_prd,
    input  logic                                   i_squash,
    // to dispatch
    output logic  [RENAME_WIDTH-1:0]               o_ren_vld,
    output preg_t [RENAME_WIDTH-1:0]               o_ren_prd,
    output preg_t [RENAME_WIDTH-1:0]               o_ren_prev_prd,
    output preg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] o_ren_prs,
    output lreg_t [RENAME_WIDTH-1:0]               o_ren_lrd,
    output logic  [RENAME_WIDTH-1:0]               o_ren_rd_wen,
    output pc_t   [RENAME_WIDTH-1:0]               o_ren_pc,
    output uop_t  [RENAME_WIDTH-1:0]               o_ren_uop
);

    logic [RENAME_WIDTH-1:0] alloc_req;
    logic                    can_rename;
    logic                    accept;

    preg_t [RENAME_WIDTH-1:0]               alloc_prd;
    preg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] prs_raw;
    preg_t [RENAME_WIDTH-1:0]               prev_prd_raw;
    preg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] prs;
    preg_t [RENAME_WIDTH-1:0]               prev_prd;

    always_comb begin
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            alloc_req[l] = i_dec_vld[l] && i_dec_rd_wen[l] && (i_dec_lrd[l] != '0);
        end
    end

    assign o_stall = !can_rename || i_stall;
    assign accept  = !o_stall && !i_squash;   // squash wins over accept

    rename_free_list u_free_list (
        .clk               (clk),
        .i_arst_n          (i_arst_n),
        .i_alloc_req       (alloc_req),
        .i_alloc_en        (accept),
        .i_commit_vld      (i_commit_vld),
        .i_commit_prd      (i_commit_prd),
        .i_commit_prev_prd (i_commit_prev_prd),
        .i_squash          (i_squash),
        .o_alloc_prd       (alloc_prd),
        .o_can_alloc       (can_rename)
    );

    rename_map_table u_map_table (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_lrs          (i_dec_lrs),
        .i_lrd          (i_dec_lrd),
        .i_wr_en        (alloc_req & {RENAME_WIDTH{accept}}),
        .i_wr_prd       (alloc_prd),
        .i_commit_vld   (i_commit_vld),
        .i_commit_lrd   (i_commit_lrd),
        .i_commit_prd   (i_commit_prd),
        .i_squash       (i_squash),
        .o_prs_raw      (prs_raw),
        .o_prev_prd_raw (prev_prd_raw)
    );

    rename_dep_check u_dep_check (
        .i_dec_lrd      (i_dec_lrd),
        .i_lane0_wr     (alloc_req[0]),
        .i_lane0_prd    (alloc_prd[0]),
        .i_lrs          (i_dec_lrs),
        .i_prs_raw      (prs_raw),
        .i_prev_prd_raw (prev_prd_raw),
        .o_prs          (prs),
        .o_prev_prd     (prev_prd)
    );

    // ******************************************************************
    // output register toward dispatch
    // ******************************************************************
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ren_vld <= '0;
        end else if (i_squash) begin
            o_ren_vld <= '0;
        end else if (!i_stall) begin
            o_ren_vld <= i_dec_vld & {RENAME_WIDTH{can_rename}};   // bubble when no regs
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            for (int l = 0; l < RENAME_WIDTH; l++) begin
                o_ren_prd[l] <= alloc_req[l] ? alloc_prd[l] : '0;
            end
            o_ren_prev_prd <= prev_prd;
            o_ren_prs      <= prs;
            o_ren_lrd      <= i_dec_lrd;
            o_ren_rd_wen   <= i_dec_rd_wen;
            o_ren_pc       <= i_dec_pc;
            o_ren_uop      <= i_dec_uop;
        end
    end

endmodule

//--- rename/rename_dep_check.sv
`timescale 1ns/1ps

module rename_dep_check import rename_pkg::*; (
    input  lreg_t [RENAME_WIDTH-1:0]               i_dec_lrd,
    input  logic                                   i_lane0_wr,
    input  preg_t                                  i_lane0_prd,
    input  lreg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] i_lrs,
    input  preg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] i_prs_raw,
    input  preg_t [RENAME_WIDTH-1:0]               i_prev_prd_raw,
    output preg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] o_prs,
    output preg_t [RENAME_WIDTH-1:0]               o_prev_prd
);

    logic                src_hit [NUM_SRCS];
    logic                rd_hit;

    // lane 0 has no older lane in the group
    always_comb begin
        for (int s = 0; s < NUM_SRCS; s++) begin
            src_hit[s] = i_lane0_wr && (i_lrs[1][s] == i_dec_lrd[0]);
        end
        rd_hit = i_lane0_wr && (i_dec_lrd[1] == i_dec_lrd[0]);
    end

    always_comb begin
        o_prs[0]      = i_prs_raw[0];
        o_prev_prd[0] = i_prev_prd_raw[0];

        for (int s = 0; s < NUM_SRCS; s++) begin
            if (src_hit[s]) begin
                o_prs[1][s] = i_lane0_prd;   // bypass lane 0 new reg
            end else begin
                o_prs[1][s] = i_prs_raw[1][s];
            end
        end

        // lane 1 replaces the mapping lane 0 just made
        if (rd_hit) begin
            o_prev_prd[1] = i_lane0_prd;
        end else begin
            o_prev_prd[1] = i_prev_prd_raw[1];
        end
    end

endmodule

//--- rename/rename_map_table.sv
`timescale 1ns/1ps

module rename_map_table import rename_pkg::*; (
    input  logic                                   clk,
    input  logic                                   i_arst_n,
    // lookups
    input  lreg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] i_lrs,
    input  lreg_t [RENAME_WIDTH-1:0]               i_lrd,
    // speculative write
    input  logic  [RENAME_WIDTH-1:0]               i_wr_en,
    input  preg_t [RENAME_WIDTH-1:0]               i_wr_prd,
    // commit
    input  logic  [RENAME_WIDTH-1:0]               i_commit_vld,
    input  lreg_t [RENAME_WIDTH-1:0]               i_commit_lrd,
    input  preg_t [RENAME_WIDTH-1:0]               i_commit_prd,
    input  logic                                   i_squash,
    output preg_t [RENAME_WIDTH-1:0][NUM_SRCS-1:0] o_prs_raw,
    output preg_t [RENAME_WIDTH-1:0]               o_prev_prd_raw
);

    preg_t spec_map       [NUM_LREGS];
    preg_t commit_map     [NUM_LREGS];
    preg_t commit_map_nxt [NUM_LREGS];

    // ******************************************************************
    // speculative lookups
    // ******************************************************************
    always_comb begin
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            o_prev_prd_raw[l] = spec_map[i_lrd[l]];
            for (int s = 0; s < NUM_SRCS; s++) begin
                o_prs_raw[l][s] = spec_map[i_lrs[l][s]];
            end
        end
    end

    // ******************************************************************
    // committed map
    // ******************************************************************
    always_comb begin
        commit_map_nxt = commit_map;
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            // x0 stays bound to p0
            if (i_commit_vld[l] && (i_commit_lrd[l] != '0)) begin
                commit_map_nxt[i_commit_lrd[l]] = i_commit_prd[l];
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_LREGS; i++) begin
                commit_map[i] <= preg_t'(i);   // identity mapping
            end
        end else begin
            commit_map <= commit_map_nxt;
        end
    end

    // ******************************************************************
    // speculative map
    // ******************************************************************
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_LREGS; i++) begin
                spec_map[i] <= preg_t'(i);
            end
        end else if (i_squash) begin
            spec_map <= commit_map_nxt;
        end else begin
            // later lane overrides on the same lrd
            for (int l = 0; l < RENAME_WIDTH; l++) begin
                if (i_wr_en[l] && (i_lrd[l] != '0)) begin
                    spec_map[i_lrd[l]] <= i_wr_prd[l];
                end
            end
        end
    end

endmodule

//--- rename/rename_free_list.sv
`timescale 1ns/1ps

module rename_free_list import rename_pkg::*; (
    input  logic                     clk,
    input  logic                     i_arst_n,
    // allocation
    input  logic [RENAME_WIDTH-1:0]  i_alloc_req,
    input  logic                     i_alloc_en,
    // commit
    input  logic [RENAME_WIDTH-1:0]  i_commit_vld,
    input  preg_t [RENAME_WIDTH-1:0] i_commit_prd,
    input  preg_t [RENAME_WIDTH-1:0] i_commit_prev_prd,
    input  logic                     i_squash,
    output preg_t [RENAME_WIDTH-1:0] o_alloc_prd,
    output logic                     o_can_alloc
);

    logic [NUM_PREGS-1:0] spec_free;
    logic [NUM_PREGS-1:0] spec_free_nxt;
    logic [NUM_PREGS-1:0] commit_free;
    logic [NUM_PREGS-1:0] commit_free_nxt;

    preg_t first_idx;
    preg_t second_idx;
    logic  first_vld;
    logic  second_vld;

    // ******************************************************************
    // two lowest free registers
    // ******************************************************************
    always_comb begin
        first_vld  = 1'b0;
        second_vld = 1'b0;
        first_idx  = '0;
        second_idx = '0;
        for (int i = 0; i < NUM_PREGS; i++) begin
            if (spec_free[i]) begin
                if (!first_vld) begin
                    first_vld = 1'b1;
                    first_idx = preg_t'(i);
                end else if (!second_vld) begin
                    second_vld = 1'b1;
                    second_idx = preg_t'(i);
                end
            end
        end
    end

    assign o_can_alloc    = second_vld;   // two or more regs free
    assign o_alloc_prd[0] = first_idx;
    assign o_alloc_prd[1] = i_alloc_req[0] ? second_idx : first_idx;

    // ******************************************************************
    // next state
    // ******************************************************************
    always_comb begin
        commit_free_nxt = commit_free;
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            if (i_commit_vld[l]) begin
                commit_free_nxt[i_commit_prd[l]] = 1'b0;
                if (i_commit_prev_prd[l] != '0) begin
                    commit_free_nxt[i_commit_prev_prd[l]] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        spec_free_nxt = spec_free;
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            if (i_alloc_en && i_alloc_req[l]) begin
                spec_free_nxt[o_alloc_prd[l]] = 1'b0;
            end
            if (i_commit_vld[l] && (i_commit_prev_prd[l] != '0)) begin
                spec_free_nxt[i_commit_prev_prd[l]] = 1'b1;   // released reg
            end
        end
        if (i_squash) begin
            spec_free_nxt = commit_free_nxt;   // includes this cycle's commits
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            spec_free   <= FREE_RESET;
            commit_free <= FREE_RESET;
        end else begin
            spec_free   <= spec_free_nxt;
            commit_free <= commit_free_nxt;
        end
    end

endmodule

//--- common/rename_pkg.sv
package rename_pkg;

    // ******************************************************************
    // core geometry
    // ******************************************************************
    localparam int RENAME_WIDTH = 2;    // lanes per decode group
    localparam int NUM_LREGS    = 32;   // architectural integer regs
    localparam int NUM_PREGS    = 48;   // physical integer regs
    localparam int NUM_SRCS     = 2;    // sources per instruction
    localparam int LREG_W       = 5;
    localparam int PREG_W       = 6;
    localparam int PC_W         = 32;
    localparam int UOP_W        = 4;

    // physical regs above the identity-mapped range start out free
    localparam logic [NUM_PREGS-1:0] FREE_RESET =
        {{(NUM_PREGS-NUM_LREGS){1'b1}}, {NUM_LREGS{1'b0}}};

    // ******************************************************************
    // types
    // ******************************************************************
    typedef logic [LREG_W-1:0] lreg_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [PC_W-1:0]   pc_t;

    typedef enum logic [UOP_W-1:0] {
        UOP_ALU     = 4'd0,
        UOP_ALU_IMM = 4'd1,
        UOP_LUI     = 4'd2,
        UOP_AUIPC   = 4'd3,
        UOP_BRANCH  = 4'd4,
        UOP_JAL     = 4'd5,
        UOP_JALR    = 4'd6,
        UOP_LOAD    = 4'd7,
        UOP_STORE   = 4'd8,
        UOP_MUL     = 4'd9,
        UOP_DIV     = 4'd10,
        UOP_CSR     = 4'd11,
        UOP_FENCE   = 4'd12,
        UOP_NOP     = 4'd15
    } uop_t;

endpackage
